//--- playfield_pkg.sv
// playfield shared types
`default_nettype none

package playfield_pkg;

    // tile codes held in the stack, anything but BLANK is occupied
    typedef enum logic [3:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        S       = 4'd4,
        Z       = 4'd5,
        J       = 4'd6,
        L       = 4'd7,
        GARBAGE = 4'd8
    } tile_t;

    localparam int DEF_ROWS = 20;
    localparam int DEF_COLS = 10;
    localparam int ROW_W    = 5;
    localparam int COL_W    = 4;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } cell_t;

    typedef struct packed {
        cell_t [3:0] cells;
        tile_t       tile;
    } piece_t;

    // count is 1 to 7 rows
    typedef struct packed {
        logic [2:0]       count;
        logic [COL_W-1:0] hole;
    } garbage_t;

    // column 0 sits in the lowest slice
    typedef tile_t [DEF_COLS-1:0] row_t;

    function automatic row_t blank_row();
        row_t r;
        for (int j = 0; j < DEF_COLS; j++) begin
            r[j] = BLANK;
        end
        return r;
    endfunction

endpackage

`default_nettype wire

//--- command_decode.sv
// lock and garbage request decode
`default_nettype none

module command_decode
    import playfield_pkg::*;
#(
    parameter int ROWS = DEF_ROWS,
    parameter int COLS = DEF_COLS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             lock_valid,
    input  logic             garbage_valid,
    input  piece_t           lock_piece,
    input  garbage_t         garbage_req,
    output logic             lock_en,
    output piece_t           lock_cmd,
    output logic             push_en,
    output logic [COL_W-1:0] hole_col,
    output logic             lock_reject,
    output logic [5:0]       garbage_pending
);
    logic       cells_ok;
    logic [6:0] pending_sum;

    // every cell has to land inside the playfield
    always_comb begin
        cells_ok = 1'b1;
        for (int c = 0; c < 4; c++) begin
            if (int'(lock_piece.cells[c].row) >= ROWS ||
                int'(lock_piece.cells[c].col) >= COLS) begin
                cells_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            lock_en     <= 1'b0;
            lock_reject <= 1'b0;
        end else begin
            lock_en     <= lock_valid && cells_ok;
            lock_reject <= lock_valid && !cells_ok;
        end
    end

    // piece travels with the strobe
    always_ff @(posedge clk) begin
        if (lock_valid) begin
            lock_cmd <= lock_piece;
        end
    end

    // a lock owns the stack, garbage waits a cycle
    assign push_en = (garbage_pending != 6'd0) && !lock_en;

    always_comb begin
        pending_sum = {1'b0, garbage_pending}
                    + (garbage_valid ? 7'(garbage_req.count) : 7'd0)
                    - (push_en ? 7'd1 : 7'd0);
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            garbage_pending <= 6'd0;
        end else if (pending_sum > 7'd63) begin
            garbage_pending <= 6'd63;
        end else begin
            garbage_pending <= pending_sum[5:0];
        end
    end

    // newest request sets the hole for all queued rows
    always_ff @(posedge clk) begin
        if (garbage_valid) begin
            hole_col <= garbage_req.hole;
        end
    end

endmodule

`default_nettype wire

//--- playfield_store.sv
// locked playfield store
`default_nettype none

module playfield_store
    import playfield_pkg::*;
#(
    parameter int ROWS = DEF_ROWS,
    parameter int COLS = DEF_COLS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             lock_en,
    input  piece_t           lock_cmd,
    input  logic             push_en,
    input  logic [COL_W-1:0] hole_col,
    input  logic [ROW_W-1:0] read_row,
    output row_t             row_cells,
    output logic [ROWS-1:0]  row_full
);
    // row 0 is the top of the stack, ROWS-1 the bottom
    row_t            field      [ROWS];
    row_t            cleared    [ROWS];
    row_t            from_above [ROWS];
    row_t            nxt        [ROWS];
    row_t            garbage_line;
    logic [ROWS-1:0] row_empty;
    logic [ROWS-1:0] below_empty;

    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            row_full[i]  = 1'b1;
            row_empty[i] = 1'b1;
            for (int j = 0; j < COLS; j++) begin
                if (field[i][j] == BLANK) begin
                    row_full[i] = 1'b0;
                end else begin
                    row_empty[i] = 1'b0;
                end
            end
        end
    end

    // full rows go blank before anything moves
    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            cleared[i] = row_full[i] ? blank_row() : field[i];
        end
        from_above[0] = blank_row();
        for (int i = 1; i < ROWS; i++) begin
            from_above[i] = cleared[i - 1];
        end
    end

    assign below_empty = row_empty >> 1;

    always_comb begin
        garbage_line = blank_row();
        for (int j = 0; j < COLS; j++) begin
            if (j != int'(hole_col)) begin
                garbage_line[j] = GARBAGE;
            end
        end
    end

    always_comb begin
        if (push_en) begin
            // whole stack rises one row, top row falls off
            for (int i = 0; i < ROWS - 1; i++) begin
                nxt[i] = cleared[i + 1];
            end
            nxt[ROWS - 1] = garbage_line;
        end else begin
            // empty row pulls the one above down and leaves a gap behind
            for (int i = 0; i < ROWS; i++) begin
                if (row_empty[i]) begin
                    nxt[i] = from_above[i];
                end else if (below_empty[i]) begin
                    nxt[i] = blank_row();
                end else begin
                    nxt[i] = cleared[i];
                end
            end
        end
        if (lock_en) begin
            for (int c = 0; c < 4; c++) begin
                nxt[lock_cmd.cells[c].row][lock_cmd.cells[c].col] = lock_cmd.tile;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            for (int i = 0; i < ROWS; i++) begin
                field[i] <= blank_row();
            end
        end else begin
            field <= nxt;
        end
    end

    assign row_cells = (int'(read_row) < ROWS) ? field[read_row] : blank_row();

endmodule

`default_nettype wire

//--- line_tally.sv
// cleared line and attack counters
`default_nettype none

module line_tally
    import playfield_pkg::*;
#(
    parameter int ROWS = DEF_ROWS
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [ROWS-1:0] row_full,
    output logic [9:0]      lines_cleared,
    output logic [9:0]      lines_sent
);
    localparam int CNT_W = $clog2(ROWS + 1);

    logic [CNT_W-1:0] full_count;
    logic [2:0]       attack;
    logic [10:0]      cleared_sum;
    logic [10:0]      sent_sum;

    always_comb begin
        full_count = '0;
        for (int i = 0; i < ROWS; i++) begin
            full_count = full_count + CNT_W'(row_full[i]);
        end
    end

    // singles send nothing, four or more send four
    always_comb begin
        if (full_count >= CNT_W'(4)) begin
            attack = 3'd4;
        end else if (full_count == CNT_W'(3)) begin
            attack = 3'd2;
        end else if (full_count == CNT_W'(2)) begin
            attack = 3'd1;
        end else begin
            attack = 3'd0;
        end
    end

    assign cleared_sum = {1'b0, lines_cleared} + 11'(full_count);
    assign sent_sum    = {1'b0, lines_sent} + 11'(attack);

    // both totals stick at the top instead of wrapping
    always_ff @(posedge clk) begin
        if (rst || start) begin
            lines_cleared <= 10'd0;
            lines_sent    <= 10'd0;
        end else begin
            lines_cleared <= cleared_sum[10] ? 10'h3ff : cleared_sum[9:0];
            lines_sent    <= sent_sum[10] ? 10'h3ff : sent_sum[9:0];
        end
    end

endmodule

`default_nettype wire

//--- playfield_top.sv
// playfield core top level
`default_nettype none

module playfield_top
    import playfield_pkg::*;
#(
    parameter int ROWS = DEF_ROWS,
    parameter int COLS = DEF_COLS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             lock_valid,
    input  piece_t           lock_piece,
    input  logic             garbage_valid,
    input  garbage_t         garbage_req,
    input  logic [ROW_W-1:0] read_row,
    output row_t             row_cells,
    output logic             lock_reject,
    output logic [5:0]       garbage_pending,
    output logic [9:0]       lines_cleared,
    output logic [9:0]       lines_sent
);
    logic             lock_en;
    piece_t           lock_cmd;
    logic             push_en;
    logic [COL_W-1:0] hole_col;
    logic [ROWS-1:0]  row_full;

    command_decode #(
        .ROWS   (ROWS),
        .COLS   (COLS)
    ) u_decode (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .lock_valid         (lock_valid),
        .garbage_valid      (garbage_valid),
        .lock_piece         (lock_piece),
        .garbage_req        (garbage_req),
        .lock_en            (lock_en),
        .lock_cmd           (lock_cmd),
        .push_en            (push_en),
        .hole_col           (hole_col),
        .lock_reject        (lock_reject),
        .garbage_pending    (garbage_pending)
    );

    playfield_store #(
        .ROWS   (ROWS),
        .COLS   (COLS)
    ) u_store (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .lock_en    (lock_en),
        .lock_cmd   (lock_cmd),
        .push_en    (push_en),
        .hole_col   (hole_col),
        .read_row   (read_row),
        .row_cells  (row_cells),
        .row_full   (row_full)
    );

    line_tally #(
        .ROWS   (ROWS)
    ) u_tally (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .row_full       (row_full),
        .lines_cleared  (lines_cleared),
        .lines_sent     (lines_sent)
    );

endmodule

`default_nettype wire

//--- playfield_assert.sv
// playfield port assertions
`default_nettype none

module playfield_assert
    import playfield_pkg::*;
#(
    parameter int ROWS = DEF_ROWS,
    parameter int COLS = DEF_COLS
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       lock_valid,
    input  piece_t     lock_piece,
    input  logic       garbage_valid,
    input  garbage_t   garbage_req,
    input  row_t       row_cells,
    input  logic       lock_reject,
    input  logic [5:0] garbage_pending,
    input  logic [9:0] lines_cleared,
    input  logic [9:0] lines_sent
);
    int   fail_count = 0;
    int   pending_age;
    logic piece_inside;

    task automatic count_failure(string what);
        fail_count++;
        $error("%s", what);
    endtask

    always_comb begin
        piece_inside = 1'b1;
        for (int c = 0; c < 4; c++) begin
            if (int'(lock_piece.cells[c].row) >= ROWS ||
                int'(lock_piece.cells[c].col) >= COLS) begin
                piece_inside = 1'b0;
            end
        end
    end

    // cycles the garbage queue has stayed non-empty
    always_ff @(posedge clk) begin
        if (rst || start || garbage_pending == 6'd0) begin
            pending_age <= 0;
        end else begin
            pending_age <= pending_age + 1;
        end
    end

    cleared_after_reset: assert property (@(posedge clk) disable iff (rst)
        $past(rst || start) |-> row_cells == '0 && lines_cleared == 10'd0 &&
            lines_sent == 10'd0 && garbage_pending == 6'd0)
        else count_failure("playfield or counters not cleared by reset or start");

    bad_lock_rejected: assert property (@(posedge clk) disable iff (rst || start)
        lock_valid && !piece_inside |=> lock_reject)
        else count_failure("lock outside the playfield was not rejected");

    reject_only_for_bad_lock: assert property (@(posedge clk) disable iff (rst)
        lock_reject |-> $past(lock_valid && !piece_inside && !start))
        else count_failure("lock_reject without a bad lock the cycle before");

    garbage_queued: assert property (@(posedge clk) disable iff (rst || start)
        garbage_valid && garbage_pending == 6'd0 |=>
            garbage_pending == {3'd0, $past(garbage_req.count)})
        else count_failure("garbage_pending did not rise by the requested count");

    garbage_steps_down: assert property (@(posedge clk) disable iff (rst || start)
        !$past(rst || start) |-> int'(garbage_pending) + 1 >= int'($past(garbage_pending)))
        else count_failure("garbage_pending dropped by more than one row");

    // 63 queued rows plus room for interleaved locks
    garbage_drains: assert property (@(posedge clk) disable iff (rst || start)
        pending_age < 128)
        else count_failure("garbage_pending never reached zero");

    totals_grow: assert property (@(posedge clk) disable iff (rst)
        !$past(rst || start) |-> lines_cleared >= $past(lines_cleared) &&
            lines_sent >= $past(lines_sent))
        else count_failure("line totals decreased without start");

endmodule

bind playfield_top playfield_assert #(
    .ROWS   (ROWS),
    .COLS   (COLS)
) port_checks (
    .clk                (clk),
    .rst                (rst),
    .start              (start),
    .lock_valid         (lock_valid),
    .lock_piece         (lock_piece),
    .garbage_valid      (garbage_valid),
    .garbage_req        (garbage_req),
    .row_cells          (row_cells),
    .lock_reject        (lock_reject),
    .garbage_pending    (garbage_pending),
    .lines_cleared      (lines_cleared),
    .lines_sent         (lines_sent)
);

`default_nettype wire

//--- tb_playfield.sv
// playfield core testbench
`default_nettype none

module tb_playfield
    import playfield_pkg::*;
();
    localparam int ROWS = DEF_ROWS;
    localparam int COLS = DEF_COLS;
    // collapse moves one row per cycle, so twice the height covers any stack
    localparam int SETTLE = 2 * ROWS;
    // the tests take well under a thousand cycles
    localparam int LIMIT = 2000;

    logic             clk;
    logic             rst;
    logic             start;
    logic             lock_valid;
    piece_t           lock_piece;
    logic             garbage_valid;
    garbage_t         garbage_req;
    logic [ROW_W-1:0] read_row;
    row_t             row_cells;
    logic             lock_reject;
    logic [5:0]       garbage_pending;
    logic [9:0]       lines_cleared;
    logic [9:0]       lines_sent;

    row_t  model [ROWS];
    int    exp_cleared;
    int    exp_sent;
    int    errors;
    int    hole;
    int    seed = 32'h28f4_a83b;

    playfield_top #(
        .ROWS   (ROWS),
        .COLS   (COLS)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog timeout, run stopped after %0d cycles", LIMIT);
        $display("Checks failed");
        $finish;
    end

    function automatic int draw(int range);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return v % range;
    endfunction

    function automatic row_t empty_row();
        row_t r;
        for (int j = 0; j < COLS; j++) begin
            r[j] = BLANK;
        end
        return r;
    endfunction

    function automatic int filled(row_t r);
        int n;
        n = 0;
        for (int j = 0; j < COLS; j++) begin
            if (r[j] != BLANK) begin
                n++;
            end
        end
        return n;
    endfunction

    // single 0, double 1, triple 2, four or more 4
    function automatic int attack_lines(int n);
        if (n >= 4) begin
            return 4;
        end
        return (n >= 2) ? n - 1 : 0;
    endfunction

    function automatic piece_t make_piece(tile_t t, int r0, int c0, int r1, int c1,
                                          int r2, int c2, int r3, int c3);
        piece_t p;
        p.tile = t;
        p.cells[0].row = ROW_W'(r0);
        p.cells[0].col = COL_W'(c0);
        p.cells[1].row = ROW_W'(r1);
        p.cells[1].col = COL_W'(c1);
        p.cells[2].row = ROW_W'(r2);
        p.cells[2].col = COL_W'(c2);
        p.cells[3].row = ROW_W'(r3);
        p.cells[3].col = COL_W'(c3);
        return p;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < ROWS; i++) begin
            model[i] = empty_row();
        end
        exp_cleared = 0;
        exp_sent = 0;
    endtask

    // full rows vanish and the rest drop onto whatever lies below
    task automatic settle_model();
        row_t kept [ROWS];
        int   full;
        int   dst;
        full = 0;
        dst = ROWS - 1;
        for (int i = 0; i < ROWS; i++) begin
            kept[i] = empty_row();
        end
        for (int i = ROWS - 1; i >= 0; i--) begin
            if (filled(model[i]) == COLS) begin
                full++;
            end else if (filled(model[i]) != 0) begin
                kept[dst] = model[i];
                dst--;
            end
        end
        model = kept;
        exp_cleared += full;
        exp_sent += attack_lines(full);
    endtask

    task automatic place(piece_t p, string name);
        bit on_field;
        on_field = 1'b1;
        for (int c = 0; c < 4; c++) begin
            if (int'(p.cells[c].row) >= ROWS || int'(p.cells[c].col) >= COLS) begin
                on_field = 1'b0;
            end
        end
        read_row <= p.cells[0].row;
        lock_valid <= 1'b1;
        lock_piece <= p;
        @(posedge clk);
        lock_valid <= 1'b0;
        // tiles land on the edge after the request is taken
        @(posedge clk);
        @(negedge clk);
        if (on_field) begin
            for (int c = 0; c < 4; c++) begin
                if (p.cells[c].row == p.cells[0].row &&
                    row_cells[p.cells[c].col] !== p.tile) begin
                    $display("Fail %s cell %0d: expected %h, actual %h", name, c,
                             p.tile, row_cells[p.cells[c].col]);
                    errors++;
                end
                model[p.cells[c].row][p.cells[c].col] = p.tile;
            end
            settle_model();
        end
        @(posedge clk);
    endtask

    task automatic send_garbage(int n, int h);
        row_t g;
        garbage_valid <= 1'b1;
        garbage_req.count <= 3'(n);
        garbage_req.hole <= COL_W'(h);
        @(posedge clk);
        garbage_valid <= 1'b0;
        for (int j = 0; j < COLS; j++) begin
            g[j] = (j == h) ? BLANK : GARBAGE;
        end
        repeat (n) begin
            for (int i = 0; i < ROWS - 1; i++) begin
                model[i] = model[i + 1];
            end
            model[ROWS - 1] = g;
        end
        settle_model();
    endtask

    task automatic check_field(string name);
        @(negedge clk);
        while (garbage_pending != 6'd0) begin
            @(negedge clk);
        end
        repeat (SETTLE) @(posedge clk);
        for (int r = 0; r < ROWS; r++) begin
            read_row <= ROW_W'(r);
            @(negedge clk);
            if (row_cells !== model[r]) begin
                $display("Fail %s row %0d: expected %h, actual %h", name, r,
                         model[r], row_cells);
                errors++;
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (lines_cleared !== 10'(exp_cleared) || lines_sent !== 10'(exp_sent)) begin
            $display("Fail %s totals: expected %0d/%0d, actual %0d/%0d", name,
                     exp_cleared, exp_sent, lines_cleared, lines_sent);
            errors++;
        end
        @(posedge clk);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        lock_valid = 1'b0;
        lock_piece = '0;
        garbage_valid = 1'b0;
        garbage_req = '0;
        read_row = '0;
        errors = 0;
        clear_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_field("reset");

        place(make_piece(tile_t'(1 + draw(7)), 19, 0, 19, 1, 19, 2, 19, 3), "lock");
        check_field("lock");

        // column 10 lies past the right wall
        place(make_piece(T, 18, 4, 18, 5, 18, 10, 17, 5), "reject");
        check_field("reject");

        hole = draw(COLS);
        send_garbage(3, hole);
        check_field("garbage");

        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        clear_model();
        check_field("start");

        // last piece completes two rows and the row above falls in
        place(make_piece(tile_t'(1 + draw(7)), 19, 0, 19, 1, 19, 2, 19, 3), "fill");
        place(make_piece(tile_t'(1 + draw(7)), 19, 4, 19, 5, 19, 6, 19, 7), "fill");
        place(make_piece(tile_t'(1 + draw(7)), 18, 0, 18, 1, 18, 2, 18, 3), "fill");
        place(make_piece(tile_t'(1 + draw(7)), 18, 4, 18, 5, 18, 6, 18, 7), "fill");
        place(make_piece(tile_t'(1 + draw(7)), 17, 2, 17, 3, 17, 4, 17, 5), "fill");
        place(make_piece(O, 18, 8, 18, 9, 19, 8, 19, 9), "fill");
        check_field("double clear");

        hole = draw(COLS);
        send_garbage(4, hole);
        check_field("garbage stack");
        place(make_piece(I, 16, hole, 17, hole, 18, hole, 19, hole), "four lines");
        check_field("four lines");

        // queued rows, stack and totals all go on start
        hole = draw(COLS);
        send_garbage(3, hole);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        clear_model();
        check_field("restart");

        $display("model mismatches: %0d, assertion failures: %0d", errors,
                 dut.port_checks.fail_count);
        if (errors == 0 && dut.port_checks.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
playfield_pkg.sv
command_decode.sv
playfield_store.sv
line_tally.sv
playfield_top.sv
playfield_assert.sv
tb_playfield.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_playfield -f vlog.f \
    && ./obj_dir/Vtb_playfield +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
